/* common/arb_pkg.sv */
// ##############################
// Sizes fixed for four requesters
// Ranks need one bit more than an index
// ##############################
`default_nettype none

package arb_pkg;

  // Requester count and index width
  localparam int NUM_REQ = 4;
  localparam int REQ_IDX_W = 2;

  // Rank spans 0 to NUM_REQ inclusive
  localparam int RANK_W = 3;

  localparam int PAYLOAD_W = 8;

  // Queue entries per requester, equal to the initial upstream credits
  localparam int IN_DEPTH = 2;
  localparam int IN_PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int IN_CNT_W = $clog2(IN_DEPTH + 1);

  // Downstream credits after reset
  localparam int OUT_CREDITS = 4;
  localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);

  typedef logic [PAYLOAD_W-1:0] payload_t;
  typedef logic [REQ_IDX_W-1:0] req_idx_t;

  // NUM_REQ is most deserving, 0 is just granted
  typedef logic [RANK_W-1:0] rank_t;

  // Output stage credit state
  typedef enum logic {
    HAS_CREDIT,
    STARVED
  } egress_state_e;

endpackage

`default_nettype wire

/* common/req_if.sv */
// ##############################
// Queue heads to the core, pop back
// ##############################
`timescale 1ns/1ps
`default_nettype none

interface req_if;
  import arb_pkg::*;

  // Queue not empty, one bit per requester
  logic [NUM_REQ-1:0] pending;

  // Head entry of every queue, valid where pending is set
  payload_t [NUM_REQ-1:0] heads;

  // One-hot pop, qualified by pop_valid
  logic [NUM_REQ-1:0] pop;
  logic pop_valid;

  modport ingress (
    output pending,
    output heads,
    input  pop,
    input  pop_valid
  );

  modport core (
    input  pending,
    input  heads,
    output pop,
    output pop_valid
  );

endinterface

`default_nettype wire

/* rtl/req_ingress.sv */
// ##############################
// Senders write only with a credit
// One credit returned per popped entry
// ##############################
`timescale 1ns/1ps
`default_nettype none

module req_ingress (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [arb_pkg::NUM_REQ-1:0]                in_valid,
  input  arb_pkg::payload_t [arb_pkg::NUM_REQ-1:0]   in_payload,
  output logic [arb_pkg::NUM_REQ-1:0]                in_credit,
  req_if.ingress                                     req_bus
);
  import arb_pkg::*;

  payload_t            mem [NUM_REQ][IN_DEPTH];
  logic [IN_PTR_W-1:0] rd_ptr [NUM_REQ];
  logic [IN_PTR_W-1:0] wr_ptr [NUM_REQ];
  logic [IN_CNT_W-1:0] count [NUM_REQ];
  logic [NUM_REQ-1:0]  pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [IN_PTR_W-1:0] next_ptr(input logic [IN_PTR_W-1:0] p);
    return (p == IN_PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Pop is only meaningful with pop_valid
  assign pop = req_bus.pop_valid ? req_bus.pop : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_REQ; r++) begin
        rd_ptr[r] <= '0;
        wr_ptr[r] <= '0;
        count[r]  <= '0;
      end
    end else begin
      for (int r = 0; r < NUM_REQ; r++) begin
        if (in_valid[r])
          wr_ptr[r] <= next_ptr(wr_ptr[r]);
        if (pop[r])
          rd_ptr[r] <= next_ptr(rd_ptr[r]);
        // Simultaneous push and pop leaves the count alone
        if (in_valid[r] && !pop[r])
          count[r] <= count[r] + 1'b1;
        else if (!in_valid[r] && pop[r])
          count[r] <= count[r] - 1'b1;
      end
    end
  end

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    for (int r = 0; r < NUM_REQ; r++) begin
      if (in_valid[r])
        mem[r][wr_ptr[r]] <= in_payload[r];
    end
  end

  // Heads and pending flags toward the core
  always_comb begin
    for (int r = 0; r < NUM_REQ; r++) begin
      req_bus.heads[r]   = mem[r][rd_ptr[r]];
      req_bus.pending[r] = (count[r] != '0);
    end
  end

  // Credit pulse in the cycle after the pop edge
  always_ff @(posedge clk) begin
    if (rst)
      in_credit <= '0;
    else
      in_credit <= pop;
  end

  for (genvar r = 0; r < NUM_REQ; r++) begin : gen_chk
    // Sender wrote without holding a credit
    no_overflow_a: assert property (@(posedge clk) disable iff (rst)
      in_valid[r] |-> (count[r] < IN_CNT_W'(IN_DEPTH)))
      else $error("write into full queue %0d", r);
    // Core popped a queue it saw as empty
    no_underflow_a: assert property (@(posedge clk) disable iff (rst)
      pop[r] |-> (count[r] != '0))
      else $error("pop from empty queue %0d", r);
  end

endmodule

`default_nettype wire

/* lru_arb/lru_arb_core.sv */
// ##############################
// One grant per cycle, gated by can_send
// Rank ties go to the lower index
// ##############################
`timescale 1ns/1ps
`default_nettype none

module lru_arb_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          can_send,
  req_if.core                           req_bus,
  output logic [arb_pkg::NUM_REQ-1:0]   grant,
  output logic                          grant_valid,
  output arb_pkg::req_idx_t             grant_src,
  output arb_pkg::payload_t             grant_payload
);
  import arb_pkg::*;

  rank_t [NUM_REQ-1:0] rank_q;
  req_idx_t            best_idx;
  rank_t               best_rank;
  logic                found;

  // Scan upward, replace only on a strictly higher rank
  always_comb begin
    found     = 1'b0;
    best_idx  = '0;
    best_rank = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (req_bus.pending[i] && (!found || (rank_q[i] > best_rank))) begin
        found     = 1'b1;
        best_idx  = req_idx_t'(i);
        best_rank = rank_q[i];
      end
    end
  end

  assign grant_valid = can_send && found;

  // One-hot decode of the winner
  always_comb begin
    grant = '0;
    if (grant_valid)
      grant[best_idx] = 1'b1;
  end

  assign grant_src     = best_idx;
  assign grant_payload = req_bus.heads[best_idx];

  // Grant doubles as the pop of the winning queue
  assign req_bus.pop       = grant;
  assign req_bus.pop_valid = grant_valid;

  // Winner drops to 0, everyone ranked below it moves up one
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REQ; i++)
        rank_q[i] <= rank_t'(NUM_REQ);
    end else if (grant_valid) begin
      for (int i = 0; i < NUM_REQ; i++) begin
        if (i == int'(best_idx))
          rank_q[i] <= '0;
        else if (rank_q[i] < best_rank)
          rank_q[i] <= rank_q[i] + 1'b1;
      end
    end
  end

  // Grant lands on exactly one requester that has a queued word
  grant_onehot_a: assert property (@(posedge clk) disable iff (rst)
    grant_valid |-> ($onehot(grant) && ((grant & ~req_bus.pending) == '0)))
    else $error("bad grant %b pending %b", grant, req_bus.pending);

endmodule

`default_nettype wire

/* lru_arb/lru_fairness_monitor.sv */
// ##############################
// Checks only, no outputs
// Own rank model, kept apart from the core
// ##############################
`timescale 1ns/1ps
`default_nettype none

module lru_fairness_monitor (
  input logic                        clk,
  input logic                        rst,
  input logic                        enable_priority_update,
  input logic [arb_pkg::NUM_REQ-1:0] request,
  input logic [arb_pkg::NUM_REQ-1:0] grant
);
  import arb_pkg::*;

  rank_t [NUM_REQ-1:0] rank_m;
  rank_t [NUM_REQ-1:0] wait_cnt;
  rank_t               granted_rank;

  // Rank of whoever holds the grant this cycle
  always_comb begin
    granted_rank = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (grant[i])
        granted_rank = rank_m[i];
    end
  end

  for (genvar i = 0; i < NUM_REQ; i++) begin : gen_model
    // Same LRU rule, written per requester
    always_ff @(posedge clk) begin
      if (rst)
        rank_m[i] <= rank_t'(NUM_REQ);
      else if (enable_priority_update && grant[i])
        rank_m[i] <= '0;
      else if (enable_priority_update && (grant != '0) && (rank_m[i] < granted_rank))
        rank_m[i] <= rank_m[i] + 1'b1;
    end

    // Grants to others while this one is requesting
    always_ff @(posedge clk) begin
      if (rst || grant[i])
        wait_cnt[i] <= '0;
      else if (enable_priority_update && (grant != '0) && request[i])
        wait_cnt[i] <= wait_cnt[i] + 1'b1;
    end

    // After every other requester had its turn, this one goes next
    grant_latency_a: assert property (@(posedge clk) disable iff (rst)
      (enable_priority_update && request[i] && (wait_cnt[i] == rank_t'(NUM_REQ - 1)))
        |-> grant[i])
      else $error("requester %0d starved", i);
  end

  for (genvar y = 0; y < NUM_REQ; y++) begin : gen_win
    for (genvar x = 0; x < NUM_REQ; x++) begin : gen_other
      if (x != y) begin : gen_pair
        // Winner y must not be outranked by a requesting x
        arb_priority_a: assert property (@(posedge clk) disable iff (rst)
          grant[y] |-> (!request[x] || (rank_m[x] < rank_m[y]) ||
                        ((rank_m[x] == rank_m[y]) && (y < x))))
          else $error("grant %0d beats higher ranked %0d", y, x);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/grant_egress.sv */
// ##############################
// Downstream may return at most OUT_CREDITS
// ##############################
`timescale 1ns/1ps
`default_nettype none

module grant_egress (
  input  logic              clk,
  input  logic              rst,
  input  logic              grant_valid,
  input  arb_pkg::req_idx_t grant_src,
  input  arb_pkg::payload_t grant_payload,
  input  logic              out_credit,
  output logic              can_send,
  output logic              out_valid,
  output arb_pkg::req_idx_t out_src,
  output arb_pkg::payload_t out_payload
);
  import arb_pkg::*;

  logic [OUT_CNT_W-1:0] credit_cnt;
  logic [OUT_CNT_W-1:0] credit_nxt;
  egress_state_e        state;

  // Returned credit in, accepted grant out
  assign credit_nxt = credit_cnt + OUT_CNT_W'(out_credit) - OUT_CNT_W'(grant_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= OUT_CNT_W'(OUT_CREDITS);
      state      <= HAS_CREDIT;
    end else begin
      credit_cnt <= credit_nxt;
      state      <= (credit_nxt != '0) ? HAS_CREDIT : STARVED;
    end
  end

  assign can_send = (state == HAS_CREDIT);

  // Word held one cycle behind the grant
  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= grant_valid;
  end

  always_ff @(posedge clk) begin
    if (grant_valid) begin
      out_src     <= grant_src;
      out_payload <= grant_payload;
    end
  end

  // Downstream returned more credits than it was given
  credit_max_a: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= OUT_CNT_W'(OUT_CREDITS))
    else $error("credit count %0d above limit", credit_cnt);

  // Core must stay quiet while starved
  no_grant_starved_a: assert property (@(posedge clk) disable iff (rst)
    grant_valid |-> (state != STARVED))
    else $error("grant with no downstream credit");

endmodule

`default_nettype wire

/* rtl/lru_arb_top.sv */
// ##############################
// Four requesters in, one word out per cycle
// ##############################
`timescale 1ns/1ps
`default_nettype none

module lru_arb_top (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [arb_pkg::NUM_REQ-1:0]              in_valid,
  input  arb_pkg::payload_t [arb_pkg::NUM_REQ-1:0] in_payload,
  output logic [arb_pkg::NUM_REQ-1:0]              in_credit,
  output logic                                     out_valid,
  output arb_pkg::req_idx_t                        out_src,
  output arb_pkg::payload_t                        out_payload,
  input  logic                                     out_credit
);
  import arb_pkg::*;

  logic [NUM_REQ-1:0] grant;
  logic               grant_valid;
  req_idx_t           grant_src;
  payload_t           grant_payload;
  logic               can_send;

  req_if req_bus ();

  req_ingress u_ingress (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_payload (in_payload),
    .in_credit  (in_credit),
    .req_bus    (req_bus.ingress)
  );

  lru_arb_core u_core (
    .clk           (clk),
    .rst           (rst),
    .can_send      (can_send),
    .req_bus       (req_bus.core),
    .grant         (grant),
    .grant_valid   (grant_valid),
    .grant_src     (grant_src),
    .grant_payload (grant_payload)
  );

  // Ranks only move on an actual grant
  lru_fairness_monitor u_monitor (
    .clk                    (clk),
    .rst                    (rst),
    .enable_priority_update (grant_valid),
    .request                (req_bus.pending),
    .grant                  (grant)
  );

  grant_egress u_egress (
    .clk           (clk),
    .rst           (rst),
    .grant_valid   (grant_valid),
    .grant_src     (grant_src),
    .grant_payload (grant_payload),
    .out_credit    (out_credit),
    .can_send      (can_send),
    .out_valid     (out_valid),
    .out_src       (out_src),
    .out_payload   (out_payload)
  );

endmodule

`default_nettype wire

/* tests/tb_lru_arb_top.sv */
// ##############################
// Senders never exceed their credits
// Model assumes writes pend from their edge
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_lru_arb_top;
  import arb_pkg::*;

  // One stimulus row and the idle cycles after its send cycle
  typedef struct packed {
    logic [NUM_REQ-1:0]     send;
    payload_t [NUM_REQ-1:0] pay;
    logic                   credit;
    logic [7:0]             idle;
  } row_t;

  logic                   clk;
  logic                   rst;
  logic [NUM_REQ-1:0]     in_valid;
  payload_t [NUM_REQ-1:0] in_payload;
  logic [NUM_REQ-1:0]     in_credit;
  logic                   out_valid;
  req_idx_t               out_src;
  payload_t               out_payload;
  logic                   out_credit;

  row_t                   rows[$];
  payload_t               model_q[NUM_REQ][$];
  logic [NUM_REQ-1:0]     staged_send;
  payload_t [NUM_REQ-1:0] staged_pay;
  int model_rank[NUM_REQ];
  int up_cred[NUM_REQ];
  int sent_cnt[NUM_REQ];
  int left_cnt[NUM_REQ];
  int pulse_cnt[NUM_REQ];
  int words_out;
  int credits_back;
  int owed;
  int word_errs;
  int credit_errs;
  int other_errs;

  lru_arb_top dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_payload  (in_payload),
    .in_credit   (in_credit),
    .out_valid   (out_valid),
    .out_src     (out_src),
    .out_payload (out_payload),
    .out_credit  (out_credit)
  );

  always #10 clk = ~clk;

  task automatic add_row(input logic [NUM_REQ-1:0] send, input logic credit, input int idle);
    row_t row;
    row.send = send;
    for (int r = 0; r < NUM_REQ; r++)
      row.pay[r] = payload_t'($urandom);
    row.credit = credit;
    row.idle   = 8'(idle);
    rows.push_back(row);
  endtask

  // Highest rank among queued requesters, ties to the lower index
  function automatic int pick_winner();
    int best;
    best = -1;
    for (int i = 0; i < NUM_REQ; i++)
      if ((model_q[i].size() != 0) && ((best < 0) || (model_rank[i] > model_rank[best])))
        best = i;
    return best;
  endfunction

  function automatic void update_ranks(input int w);
    int win_rank;
    win_rank = model_rank[w];
    for (int i = 0; i < NUM_REQ; i++) begin
      if (i == w)
        model_rank[i] = 0;
      else if (model_rank[i] < win_rank)
        model_rank[i]++;
    end
  endfunction

  task automatic check_word(input req_idx_t exp_src, input payload_t exp_pay);
    if (out_src !== exp_src) begin
      $display("FAILED t=%0t out_src: expected %0d, got %0d", $time, exp_src, out_src);
      word_errs++;
    end
    if (out_payload !== exp_pay) begin
      $display("FAILED t=%0t out_payload: expected %02h, got %02h", $time, exp_pay, out_payload);
      word_errs++;
    end
  endtask

  // One pulse per word that has left and never ahead of it
  task automatic check_credit(input req_idx_t r);
    pulse_cnt[r]++;
    up_cred[r]++;
    if (pulse_cnt[r] > left_cnt[r]) begin
      $display("Error at %0t: credit pulse to requester %0d before its word left", $time, r);
      credit_errs++;
    end
  endtask

  // Sampled on the falling edge half a cycle after outputs settle
  task automatic observe();
    int w;
    if (out_valid) begin
      w = pick_winner();
      if (w < 0) begin
        $display("Error at %0t: output word with nothing queued", $time);
        other_errs++;
      end else begin
        check_word(req_idx_t'(w), model_q[w][0]);
        model_q[w].delete(0);
        update_ranks(w);
        left_cnt[w]++;
        words_out++;
        owed++;
        if (words_out > OUT_CREDITS + credits_back) begin
          $display("Error at %0t: more words out than downstream credits allow", $time);
          other_errs++;
        end
      end
    end
    for (int r = 0; r < NUM_REQ; r++)
      if (in_credit[r])
        check_credit(req_idx_t'(r));
  endtask

  task automatic step(input logic [NUM_REQ-1:0] mask, input payload_t [NUM_REQ-1:0] pay,
                      input logic give_credit);
    logic [NUM_REQ-1:0] send;
    @(negedge clk);
    observe();
    // Last cycle's writes become pending at the edge just passed
    for (int r = 0; r < NUM_REQ; r++)
      if (staged_send[r])
        model_q[r].push_back(staged_pay[r]);
    for (int r = 0; r < NUM_REQ; r++) begin
      send[r] = mask[r] && (up_cred[r] > 0);
      if (send[r]) begin
        up_cred[r]--;
        sent_cnt[r]++;
      end
    end
    in_valid    = send;
    in_payload  = pay;
    staged_send = send;
    staged_pay  = pay;
    // Return only credits that downstream actually holds
    out_credit = give_credit && (owed > 0);
    if (out_credit) begin
      owed--;
      credits_back++;
    end
  endtask

  function automatic bit drained();
    bit done;
    done = (staged_send == '0) && (owed == 0);
    for (int r = 0; r < NUM_REQ; r++)
      if ((model_q[r].size() != 0) || (up_cred[r] != IN_DEPTH))
        done = 1'b0;
    return done;
  endfunction

  task automatic watchdog(input int limit_ns);
    #(limit_ns);
    $display("Timeout after %0d ns, DUT stopped producing output", limit_ns);
    $display("TB FAILED");
    $finish;
  endtask

  initial begin
    int max_idle;
    void'($urandom(50901));
    clk = 1'b0;
    rst = 1'b1;
    in_valid = '0;
    in_payload = '0;
    out_credit = 1'b0;
    staged_send = '0;
    staged_pay = '0;
    words_out = 0;
    credits_back = 0;
    owed = 0;
    word_errs = 0;
    credit_errs = 0;
    other_errs = 0;
    for (int r = 0; r < NUM_REQ; r++) begin
      model_rank[r] = NUM_REQ;
      up_cred[r] = IN_DEPTH;
      sent_cnt[r] = 0;
      left_cnt[r] = 0;
      pulse_cnt[r] = 0;
    end
    // Idle, single requester, full contention, partial bursts, back-pressure
    add_row(4'b0000, 1'b0, 4);
    add_row(4'b0001, 1'b1, 0);
    add_row(4'b0001, 1'b1, 0);
    add_row(4'b0001, 1'b1, 3);
    for (int i = 0; i < 5; i++)
      add_row(4'b1111, 1'b1, 0);
    add_row(4'b0110, 1'b1, 1);
    add_row(4'b1010, 1'b1, 0);
    add_row(4'b0101, 1'b1, 3);
    add_row(4'b1111, 1'b0, 0);
    add_row(4'b1111, 1'b0, 0);
    add_row(4'b1111, 1'b0, 6);
    add_row(4'b1100, 1'b1, 2);
    max_idle = 0;
    foreach (rows[i])
      if (int'(rows[i].idle) > max_idle)
        max_idle = int'(rows[i].idle);
    fork
      watchdog(rows.size() * (max_idle + 20) * 20);
    join_none
    // Outputs stay quiet through reset
    repeat (5) begin
      @(negedge clk);
      if ((out_valid !== 1'b0) || (in_credit !== '0)) begin
        $display("Error at %0t: output active during reset", $time);
        other_errs++;
      end
    end
    rst = 1'b0;
    foreach (rows[i]) begin
      step(rows[i].send, rows[i].pay, rows[i].credit);
      repeat (rows[i].idle)
        step('0, '0, rows[i].credit);
    end
    while (!drained())
      step('0, '0, 1'b1);
    repeat (4)
      step('0, '0, 1'b0);
    for (int r = 0; r < NUM_REQ; r++)
      if (pulse_cnt[r] != sent_cnt[r]) begin
        $display("Error: requester %0d sent %0d words, got %0d credits back", r,
                 sent_cnt[r], pulse_cnt[r]);
        credit_errs++;
      end
    $display("Checks done: %0d word errors, %0d credit errors, %0d other errors",
             word_errs, credit_errs, other_errs);
    if (word_errs + credit_errs + other_errs == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/arb_pkg.sv
common/req_if.sv
rtl/req_ingress.sv
lru_arb/lru_arb_core.sv
lru_arb/lru_fairness_monitor.sv
rtl/grant_egress.sv
rtl/lru_arb_top.sv
tests/tb_lru_arb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_lru_arb_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
